//--- src/pulse_filter_config.svh
`ifndef PULSE_FILTER_CONFIG_SVH
`define PULSE_FILTER_CONFIG_SVH

//----------------------------------------------------------------------------
// Sample path
//----------------------------------------------------------------------------
// ADC sample width, unsigned
`define ADC_W		12
// Samples in one stored pulse
`define PULSE_LEN	32
// Pulse spacing register width
`define PERIOD_W	10

//----------------------------------------------------------------------------
// Filters
//----------------------------------------------------------------------------
// Moving-sum window, power of two
`define MSUM_LEN	8
`define MSUM_W		(`ADC_W + $clog2(`MSUM_LEN))
// Smoothing shift, gain of 1/8
`define EXP_K		3
`define EXP_W		(`ADC_W + `EXP_K)

//----------------------------------------------------------------------------
// APB register map
//----------------------------------------------------------------------------
`define APB_AW		4
`define APB_DW		32
`define CNT_W		16
`define REG_CTRL	4'h0
`define REG_PERIOD	4'h4
`define REG_PCOUNT	4'h8

`endif

//--- src/pulse_filter_pkg.sv
`include "pulse_filter_config.svh"

package pulse_filter_pkg;

	//------------------------------------------------------------------------
	// Plain vectors
	//------------------------------------------------------------------------
	// Raw sample value
	typedef logic [`ADC_W-1:0] adc_data_t;
	// Distance between pulses, in samples
	typedef logic [`PERIOD_W-1:0] period_t;
	// Moving-sum result
	typedef logic [`MSUM_W-1:0] msum_data_t;
	// Smoothing accumulator, sample scaled by 2^EXP_K
	typedef logic [`EXP_W-1:0] exp_data_t;
	// Started-pulse counter
	typedef logic [`CNT_W-1:0] pcount_t;
	// Position inside the pulse shape
	typedef logic [$clog2(`PULSE_LEN)-1:0] shape_idx_t;

	//------------------------------------------------------------------------
	// Bundles
	//------------------------------------------------------------------------
	// Generator setup from the register block
	typedef struct packed {
		logic		enable;
		logic		overlay;
		logic		fast_rate;
		period_t	period;
	} gen_cfg_t;

	// Valid-qualified streams, no handshake
	typedef struct packed {
		logic		valid;
		adc_data_t	data;
	} adc_sample_t;

	typedef struct packed {
		logic		valid;
		msum_data_t	data;
	} msum_sample_t;

	typedef struct packed {
		logic		valid;
		exp_data_t	data;
	} exp_sample_t;

endpackage

//--- src/pulse_shape_rom.sv
// Exponential pulse shape table
// v0 = 3840, v(i+1) = v(i) - (v(i) >> 3), truncated
// Decay of about 1/8 per sample, tail ends near 65
module pulse_shape_rom (
	input  pulse_filter_pkg::shape_idx_t	idx,
	output pulse_filter_pkg::adc_data_t		value
);
	import pulse_filter_pkg::*;

	always_comb begin
		case (idx)
			// Rising edge is instant, peak first
			5'd0:  value = adc_data_t'(3840);
			5'd1:  value = adc_data_t'(3360);
			5'd2:  value = adc_data_t'(2940);
			5'd3:  value = adc_data_t'(2573);
			5'd4:  value = adc_data_t'(2252);
			5'd5:  value = adc_data_t'(1971);
			5'd6:  value = adc_data_t'(1725);
			5'd7:  value = adc_data_t'(1510);
			// Second quarter
			5'd8:  value = adc_data_t'(1322);
			5'd9:  value = adc_data_t'(1157);
			5'd10: value = adc_data_t'(1013);
			5'd11: value = adc_data_t'(887);
			5'd12: value = adc_data_t'(777);
			5'd13: value = adc_data_t'(680);
			5'd14: value = adc_data_t'(595);
			5'd15: value = adc_data_t'(521);
			// Third quarter
			5'd16: value = adc_data_t'(456);
			5'd17: value = adc_data_t'(399);
			5'd18: value = adc_data_t'(350);
			5'd19: value = adc_data_t'(307);
			5'd20: value = adc_data_t'(269);
			5'd21: value = adc_data_t'(236);
			5'd22: value = adc_data_t'(207);
			5'd23: value = adc_data_t'(182);
			// Tail
			5'd24: value = adc_data_t'(160);
			5'd25: value = adc_data_t'(140);
			5'd26: value = adc_data_t'(123);
			5'd27: value = adc_data_t'(108);
			5'd28: value = adc_data_t'(95);
			5'd29: value = adc_data_t'(84);
			5'd30: value = adc_data_t'(74);
			5'd31: value = adc_data_t'(65);
			default: value = '0;
		endcase
	end

endmodule

//--- src/test_pulse_gen.sv
`include "pulse_filter_config.svh"

// Test pulse source standing in for the ADC
module test_pulse_gen (
	input  logic							clk,
	input  logic							rst_n,
	input  pulse_filter_pkg::gen_cfg_t		cfg,
	output pulse_filter_pkg::adc_sample_t	sample,
	output logic							pulse_start
);
	import pulse_filter_pkg::*;

	localparam shape_idx_t LAST_POS = shape_idx_t'(`PULSE_LEN - 1);

	logic [1:0]		div_cnt;
	logic			tick;
	period_t		sched_cnt;
	period_t		reload;
	logic			due;
	logic			start;
	logic [1:0]		busy;
	logic [1:0]		busy_eff;
	logic [1:0]		start_sel;
	logic			older;
	shape_idx_t		pos [2];
	shape_idx_t		pos_eff [2];
	adc_data_t		rom_val [2];
	logic [`ADC_W:0]	sum;
	adc_data_t		sat;
	logic			valid_q;
	adc_data_t		data_q;

	//------------------------------------------------------------------------
	// Sample rate and pulse schedule
	//------------------------------------------------------------------------
	// Quarter rate ticks when the divider wraps
	assign tick = cfg.enable && (cfg.fast_rate || div_cnt == 2'd0);

	// Countdown at zero means a pulse is owed
	assign due = (sched_cnt == '0);
	// Without overlay a due pulse waits for both pointers to go idle
	assign start = due && (cfg.overlay || busy == 2'b00);
	// Period 0 or 1 both mean a pulse on every sample
	assign reload = (cfg.period == '0) ? '0 : cfg.period - period_t'(1);

	// Pointer pick: first free one, else restart the older
	always_comb begin
		start_sel = 2'b00;
		if (start) begin
			if (!busy[0])
				start_sel = 2'b01;
			else if (!busy[1])
				start_sel = 2'b10;
			else
				start_sel = older ? 2'b10 : 2'b01;
		end
	end

	//------------------------------------------------------------------------
	// Playback pointers and overlay sum
	//------------------------------------------------------------------------
	// State as seen by the current sample, new pulse plays from position 0
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			busy_eff[k] = busy[k] | start_sel[k];
			pos_eff[k] = start_sel[k] ? '0 : pos[k];
		end
	end

	for (genvar g = 0; g < 2; g++) begin : g_rom
		pulse_shape_rom i_pulse_shape_rom (
			.idx	(pos_eff[g]),
			.value	(rom_val[g])
		);
	end

	// One extra bit catches the carry for saturation
	assign sum = {1'b0, busy_eff[0] ? rom_val[0] : '0} +
		{1'b0, busy_eff[1] ? rom_val[1] : '0};
	assign sat = sum[`ADC_W] ? '1 : sum[`ADC_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			sched_cnt <= '0;
			busy <= '0;
			pos[0] <= '0;
			pos[1] <= '0;
			older <= 1'b0;
			valid_q <= 1'b0;
			pulse_start <= 1'b0;
		end else if (!cfg.enable) begin
			// Disabled: index and pointers restart on next enable
			div_cnt <= '0;
			sched_cnt <= '0;
			busy <= '0;
			pos[0] <= '0;
			pos[1] <= '0;
			older <= 1'b0;
			valid_q <= 1'b0;
			pulse_start <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 2'd1;
			valid_q <= tick;
			pulse_start <= tick && start;
			if (tick) begin
				// Next pulse P samples after the actual start
				if (start)
					sched_cnt <= reload;
				else if (!due)
					sched_cnt <= sched_cnt - period_t'(1);
				// Untouched pointer becomes the older one
				if (start)
					older <= start_sel[0];
				for (int k = 0; k < 2; k++) begin
					busy[k] <= busy_eff[k] && (pos_eff[k] != LAST_POS);
					pos[k] <= pos_eff[k] + shape_idx_t'(1);
				end
			end
		end
	end

	// Sample payload
	always_ff @(posedge clk) begin
		if (tick)
			data_q <= sat;
	end

	assign sample = '{valid: valid_q, data: data_q};

endmodule

//--- src/moving_sum_filter.sv
`include "pulse_filter_config.svh"

// Box shaper over the last DEPTH samples
module moving_sum_filter #(
	parameter int DEPTH = `MSUM_LEN
) (
	input  logic							clk,
	input  logic							rst_n,
	input  pulse_filter_pkg::adc_sample_t	in_sample,
	output pulse_filter_pkg::msum_sample_t	out_sample
);
	import pulse_filter_pkg::*;

	// Oldest sample sits at the far end
	adc_data_t	line_q [DEPTH];
	msum_data_t	sum_q;
	logic		valid_q;

	//------------------------------------------------------------------------
	// Running sum, add newest and drop oldest
	//------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				line_q[i] <= '0;
			sum_q <= '0;
			valid_q <= 1'b0;
		end else begin
			// Output valid one clock after input valid
			valid_q <= in_sample.valid;
			if (in_sample.valid) begin
				sum_q <= sum_q + msum_data_t'(in_sample.data) -
					msum_data_t'(line_q[DEPTH-1]);
				// Shift only on real samples, idle clocks ignored
				line_q[0] <= in_sample.data;
				for (int i = 1; i < DEPTH; i++)
					line_q[i] <= line_q[i-1];
			end
		end
	end

	// Sum holds its value between samples
	assign out_sample = '{valid: valid_q, data: sum_q};

endmodule

//--- src/exp_smooth_filter.sv
`include "pulse_filter_config.svh"

// First-order IIR smoother
// acc += x - acc/2^EXP_K, settles at x scaled by 2^EXP_K
module exp_smooth_filter (
	input  logic							clk,
	input  logic							rst_n,
	input  pulse_filter_pkg::adc_sample_t	in_sample,
	output pulse_filter_pkg::exp_sample_t	out_sample
);
	import pulse_filter_pkg::*;

	exp_data_t	acc_q;
	exp_data_t	acc_next;
	logic		valid_q;

	//------------------------------------------------------------------------
	// Accumulator update
	//------------------------------------------------------------------------
	// Headroom of EXP_K bits keeps full-scale input in range
	assign acc_next = acc_q + exp_data_t'(in_sample.data) - (acc_q >> `EXP_K);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_q <= '0;
			valid_q <= 1'b0;
		end else begin
			// Output valid one clock after input valid
			valid_q <= in_sample.valid;
			if (in_sample.valid)
				acc_q <= acc_next;
		end
	end

	// Scaled accumulator goes out as is
	assign out_sample = '{valid: valid_q, data: acc_q};

endmodule

//--- src/apb_test_regs.sv
`include "pulse_filter_config.svh"

// Generator setup registers, zero-wait APB slave
module apb_test_regs (
	input  logic						clk,
	input  logic						rst_n,
	input  logic						psel,
	input  logic						penable,
	input  logic						pwrite,
	input  logic [`APB_AW-1:0]			paddr,
	input  logic [`APB_DW-1:0]			pwdata,
	output logic [`APB_DW-1:0]			prdata,
	output logic						pready,
	output logic						pslverr,
	output pulse_filter_pkg::gen_cfg_t	cfg,
	input  logic						pulse_start
);
	import pulse_filter_pkg::*;

	logic		access;
	logic		addr_hit;
	logic		ctrl_we;
	logic		period_we;
	logic		enable_q;
	logic		overlay_q;
	logic		fast_rate_q;
	period_t	period_q;
	pcount_t	pcount_q;

	//------------------------------------------------------------------------
	// Access phase decode
	//------------------------------------------------------------------------
	assign access = psel && penable;
	assign addr_hit = (paddr == `REG_CTRL) || (paddr == `REG_PERIOD) ||
		(paddr == `REG_PCOUNT);

	assign ctrl_we = access && pwrite && (paddr == `REG_CTRL);
	assign period_we = access && pwrite && (paddr == `REG_PERIOD);

	// No wait states
	assign pready = 1'b1;
	// Error only on unmapped offsets
	assign pslverr = access && !addr_hit;

	//------------------------------------------------------------------------
	// Registers
	//------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable_q <= 1'b0;
			overlay_q <= 1'b0;
			fast_rate_q <= 1'b0;
			period_q <= '0;
			pcount_q <= '0;
		end else begin
			// CTRL bits: 0 enable, 1 overlay, 2 fast_rate
			if (ctrl_we) begin
				enable_q <= pwdata[0];
				overlay_q <= pwdata[1];
				fast_rate_q <= pwdata[2];
			end
			if (period_we)
				period_q <= pwdata[`PERIOD_W-1:0];
			// Free-running count, wraps
			if (pulse_start)
				pcount_q <= pcount_q + pcount_t'(1);
		end
	end

	// Read mux, unmapped reads zero
	always_comb begin
		prdata = '0;
		case (paddr)
			`REG_CTRL:   prdata[2:0] = {fast_rate_q, overlay_q, enable_q};
			`REG_PERIOD: prdata[`PERIOD_W-1:0] = period_q;
			`REG_PCOUNT: prdata[`CNT_W-1:0] = pcount_q;
			default:     prdata = '0;
		endcase
	end

	assign cfg = '{
		enable:    enable_q,
		overlay:   overlay_q,
		fast_rate: fast_rate_q,
		period:    period_q
	};

endmodule

//--- src/pulse_filter_top.sv
`include "pulse_filter_config.svh"

// Pulse generator with two shaping filters, setup over APB
module pulse_filter_top (
	input  logic							clk,
	input  logic							rst_n,
	// APB slave
	input  logic							psel,
	input  logic							penable,
	input  logic							pwrite,
	input  logic [`APB_AW-1:0]				paddr,
	input  logic [`APB_DW-1:0]				pwdata,
	output logic [`APB_DW-1:0]				prdata,
	output logic							pready,
	output logic							pslverr,
	// Sample streams
	output pulse_filter_pkg::adc_sample_t	raw_sample,
	output pulse_filter_pkg::msum_sample_t	msum_out,
	output pulse_filter_pkg::exp_sample_t	exp_out
);
	import pulse_filter_pkg::*;

	gen_cfg_t	cfg;
	logic		pulse_start;

	//------------------------------------------------------------------------
	// Control
	//------------------------------------------------------------------------
	apb_test_regs i_apb_test_regs (
		.clk			(clk),
		.rst_n			(rst_n),
		.psel			(psel),
		.penable		(penable),
		.pwrite			(pwrite),
		.paddr			(paddr),
		.pwdata			(pwdata),
		.prdata			(prdata),
		.pready			(pready),
		.pslverr		(pslverr),
		.cfg			(cfg),
		.pulse_start	(pulse_start)
	);

	//------------------------------------------------------------------------
	// Source and shapers
	//------------------------------------------------------------------------
	test_pulse_gen i_test_pulse_gen (
		.clk			(clk),
		.rst_n			(rst_n),
		.cfg			(cfg),
		.sample			(raw_sample),
		.pulse_start	(pulse_start)
	);

	// Both filters see the same raw stream
	moving_sum_filter i_moving_sum_filter (
		.clk			(clk),
		.rst_n			(rst_n),
		.in_sample		(raw_sample),
		.out_sample		(msum_out)
	);

	exp_smooth_filter i_exp_smooth_filter (
		.clk			(clk),
		.rst_n			(rst_n),
		.in_sample		(raw_sample),
		.out_sample		(exp_out)
	);

endmodule

//--- verif/pulse_filter_tb.sv
`include "pulse_filter_config.svh"

module pulse_filter_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import pulse_filter_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RUN_LEN = 200;
	localparam int N_RUNS = 4;
	// Every run timed as quarter rate, plus APB and reset overhead
	localparam int WATCHDOG_NS = (RUN_LEN * N_RUNS * 4 + 1000) * CLK_PERIOD;
	localparam int MSUM_MASK = (1 << `MSUM_W) - 1;
	localparam int EXP_MASK = (1 << `EXP_W) - 1;

	logic				clk;
	logic				rst_n;
	logic				psel;
	logic				penable;
	logic				pwrite;
	logic [`APB_AW-1:0]	paddr;
	logic [`APB_DW-1:0]	pwdata;
	logic [`APB_DW-1:0]	prdata;
	logic				pready;
	logic				pslverr;
	adc_sample_t		raw_sample;
	msum_sample_t		msum_out;
	exp_sample_t		exp_out;

	// Current run setup, seen by the compare process
	int		seed;
	int		run_period;
	bit		run_overlay;
	bit		run_fast;
	bit		stopped;
	int		sample_idx;
	// Compare process state
	int		cycle;
	int		last_valid_cycle;
	int		starts_seen;
	int		model_val;
	bit		model_start;
	bit		raw_valid_d;
	int		msum_expect;
	int		exp_acc;
	int		raw_hist [$];
	int		period;
	logic [`APB_DW-1:0]	rdata;
	logic		rerr;

	pulse_filter_top i_pulse_filter_top (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//--------------------------------------------------------------------------
	// Reference models
	//--------------------------------------------------------------------------
	// Peak 3840, each step loses one eighth, truncated
	function automatic int shape_ref(input int idx);
		int v;
		v = 3840;
		for (int i = 0; i < idx; i++)
			v = v - (v >> 3);
		return v;
	endfunction

	// Steps scheduler and both pointers from index 0 up to n
	function automatic int model_sample(input int n, input int per, input bit ovl,
			output bit started);
		int next_start;
		int pos [2];
		int born [2];
		bit busy [2];
		int slot;
		int value;
		next_start = 0;
		value = 0;
		started = 1'b0;
		for (int k = 0; k < 2; k++) begin
			pos[k] = 0;
			born[k] = 0;
			busy[k] = 1'b0;
		end
		for (int i = 0; i <= n; i++) begin
			// Due pulse waits for an idle source unless overlay
			started = (i >= next_start) && (ovl || (!busy[0] && !busy[1]));
			if (started) begin
				if (!busy[0])
					slot = 0;
				else if (!busy[1])
					slot = 1;
				else
					slot = (born[0] < born[1]) ? 0 : 1;
				busy[slot] = 1'b1;
				pos[slot] = 0;
				born[slot] = i;
				next_start = i + per;
			end
			value = 0;
			for (int k = 0; k < 2; k++)
				if (busy[k])
					value += shape_ref(pos[k]);
			if (value > 4095)
				value = 4095;
			for (int k = 0; k < 2; k++)
				if (busy[k]) begin
					if (pos[k] == `PULSE_LEN - 1)
						busy[k] = 1'b0;
					else
						pos[k]++;
				end
		end
		return value;
	endfunction

	// Sum of the newest window of samples, zeros before the first
	function automatic int msum_ref(input int hist [$]);
		int sum;
		sum = 0;
		for (int i = 0; i < `MSUM_LEN && i < hist.size(); i++)
			sum += hist[hist.size() - 1 - i];
		return sum & MSUM_MASK;
	endfunction

	function automatic int exp_step(input int acc, input int x);
		return (acc + x - (acc >> `EXP_K)) & EXP_MASK;
	endfunction

	function automatic int rand_period(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	//--------------------------------------------------------------------------
	// Checks and bus tasks
	//--------------------------------------------------------------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected)
			report_failure($sformatf("mismatch at %0d ns: %s got %0d, expected %0d",
				$time, name, actual, expected));
	endtask

	// Setup edge, access edge, then idle
	task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [`APB_DW-1:0] data,
			output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		// Zero-wait slave, sample mid access phase
		@(negedge clk);
		check_value("pready", int'(pready), 1);
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// One enable window of n samples, then disable and watch for silence
	task automatic run_stream(input int n, input int per, input bit ovl, input bit fast);
		run_period = per;
		run_overlay = ovl;
		run_fast = fast;
		sample_idx = 0;
		apb_write(`REG_PERIOD, 32'(per));
		stopped = 1'b0;
		apb_write(`REG_CTRL, {29'd0, fast, ovl, 1'b1});
		wait (sample_idx >= n);
		apb_write(`REG_CTRL, 32'd0);
		// Last tick before the write may still land
		repeat (2) @(posedge clk);
		stopped = 1'b1;
		repeat (8) @(posedge clk);
	endtask

	//--------------------------------------------------------------------------
	// Compare process
	//--------------------------------------------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			cycle++;
			// Filters answer one clock after each raw sample
			check_value("msum_out.valid", int'(msum_out.valid), int'(raw_valid_d));
			check_value("exp_out.valid", int'(exp_out.valid), int'(raw_valid_d));
			if (raw_valid_d) begin
				check_value("msum_out.data", int'(msum_out.data), msum_expect);
				check_value("exp_out.data", int'(exp_out.data), exp_acc);
			end
			raw_valid_d = raw_sample.valid;
			model_start = 1'b0;
			if (raw_sample.valid) begin
				check_value("raw_sample.valid", 1, stopped ? 0 : 1);
				model_val = model_sample(sample_idx, run_period, run_overlay, model_start);
				check_value("raw_sample.data", int'(raw_sample.data), model_val);
				if (!run_fast && sample_idx > 0)
					check_value("raw_sample.valid spacing", cycle - last_valid_cycle, 4);
				// No overlap possible, starts land on the plain schedule
				if (!run_overlay && run_period >= `PULSE_LEN)
					check_value("pulse_start on period", int'(i_pulse_filter_top.pulse_start),
						int'(sample_idx % run_period == 0));
				raw_hist.push_back(int'(raw_sample.data));
				msum_expect = msum_ref(raw_hist);
				exp_acc = exp_step(exp_acc, int'(raw_sample.data));
				last_valid_cycle = cycle;
				sample_idx++;
			end
			check_value("pulse_start", int'(i_pulse_filter_top.pulse_start), int'(model_start));
			if (i_pulse_filter_top.pulse_start)
				starts_seen++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
	end

	//--------------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------------
	initial begin
		seed = 32'hff1bfa31;
		stopped = 1'b1;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Register access
		apb_read(`REG_PCOUNT, rdata, rerr);
		check_value("prdata PCOUNT after reset", int'(rdata), 0);
		check_value("pslverr PCOUNT", int'(rerr), 0);
		apb_write(`REG_PERIOD, 32'h2a5);
		apb_read(`REG_PERIOD, rdata, rerr);
		check_value("prdata PERIOD", int'(rdata), 'h2a5);
		check_value("pslverr PERIOD", int'(rerr), 0);
		apb_write(`REG_CTRL, 32'h6);
		apb_read(`REG_CTRL, rdata, rerr);
		check_value("prdata CTRL", int'(rdata), 6);
		apb_write(`REG_CTRL, 32'h0);
		apb_read(4'hc, rdata, rerr);
		check_value("pslverr unmapped", int'(rerr), 1);
		check_value("prdata unmapped", int'(rdata), 0);

		// Full rate, one pulse at a time
		period = rand_period(32, 60);
		run_stream(RUN_LEN, period, 1'b0, 1'b1);
		// Short period, overlapping then deferred
		period = rand_period(8, 31);
		run_stream(RUN_LEN, period, 1'b1, 1'b1);
		run_stream(RUN_LEN, period, 1'b0, 1'b1);
		// Quarter rate
		period = rand_period(8, 60);
		run_stream(RUN_LEN, period, 1'b1, 1'b0);

		apb_read(`REG_PCOUNT, rdata, rerr);
		check_value("prdata PCOUNT", int'(rdata), starts_seen & 16'hffff);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- flist.f
+incdir+src
src/pulse_filter_pkg.sv
src/pulse_shape_rom.sv
src/test_pulse_gen.sv
src/moving_sum_filter.sv
src/exp_smooth_filter.sv
src/apb_test_regs.sv
src/pulse_filter_top.sv
verif/pulse_filter_tb.sv

//--- Makefile
TOP := pulse_filter_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
